// File: design/bf_consts.svh
`ifndef BF_CONSTS_SVH
`define BF_CONSTS_SVH

// --------------------------------------------------
// frame geometry.
// --------------------------------------------------
`define BF_COLS 16
`define BF_ROWS 12

// square window side.
`define BF_WIN 9

// clocks from the pixel accept edge to o_valid.
`define BF_LAT 8

// width of the column and row counters.
`define BF_CNT_W 10

`endif

// File: design/bf_pkg.sv
`default_nettype none
`include "bf_consts.svh"

package bf_pkg;

  // one grayscale sample.
  typedef logic [7:0] pix_t;

  // sum of one 9-pixel column.
  typedef logic [11:0] col_sum_t;

  // sum of the full 9x9 window, 81 pixels.
  typedef logic [14:0] win_sum_t;

  // column or row position inside the frame.
  typedef logic [`BF_CNT_W-1:0] cnt_t;

  // frame controller.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_RUN,
    ST_DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/line_buffer.sv
`timescale 1ns/100ps
`default_nettype none
`include "bf_consts.svh"

module line_buffer
  import bf_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic i_pix_valid,
  input  pix_t i_pix,
  output pix_t o_p1,
  output pix_t o_p2,
  output pix_t o_p3,
  output pix_t o_p4,
  output pix_t o_p5,
  output pix_t o_p6,
  output pix_t o_p7,
  output pix_t o_p8,
  output pix_t o_p9
);

  localparam int DEPTH = `BF_COLS;
  localparam int NROWS = `BF_WIN - 1;
  localparam int PTR_W = $clog2(DEPTH);

  pix_t             row_mem [NROWS][DEPTH];
  pix_t             rd_col  [NROWS];
  pix_t             pix_q;
  logic             vld_q;
  logic [PTR_W-1:0] wr_ptr;

  // accept stage.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_q <= '0;
      vld_q <= 1'b0;
    end else begin
      pix_q <= i_pix;
      vld_q <= i_pix_valid;
    end
  end

  // row_mem[0] holds the oldest row.
  always_comb begin
    for (int k = 0; k < NROWS; k++) begin
      rd_col[k] = row_mem[k][wr_ptr];
    end
  end

  // push the column up by one row.
  always_ff @(posedge clk) begin
    if (vld_q) begin
      for (int k = 0; k < NROWS - 1; k++) begin
        row_mem[k][wr_ptr] <= rd_col[k+1];
      end
      row_mem[NROWS-1][wr_ptr] <= pix_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      o_p1   <= '0;
      o_p2   <= '0;
      o_p3   <= '0;
      o_p4   <= '0;
      o_p5   <= '0;
      o_p6   <= '0;
      o_p7   <= '0;
      o_p8   <= '0;
      o_p9   <= '0;
    end else if (vld_q) begin
      wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      o_p1   <= rd_col[0];
      o_p2   <= rd_col[1];
      o_p3   <= rd_col[2];
      o_p4   <= rd_col[3];
      o_p5   <= rd_col[4];
      o_p6   <= rd_col[5];
      o_p7   <= rd_col[6];
      o_p8   <= rd_col[7];
      o_p9   <= pix_q;
    end
  end

endmodule

`default_nettype wire

// File: design/window_sum.sv
`timescale 1ns/100ps
`default_nettype none
`include "bf_consts.svh"

module window_sum
  import bf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  pix_t     i_p1,
  input  pix_t     i_p2,
  input  pix_t     i_p3,
  input  pix_t     i_p4,
  input  pix_t     i_p5,
  input  pix_t     i_p6,
  input  pix_t     i_p7,
  input  pix_t     i_p8,
  input  pix_t     i_p9,
  input  logic     i_valid,
  input  logic     i_clr,
  input  logic     i_ld_en,
  input  logic     i_sub_en,
  output cnt_t     o_col_idx,
  output cnt_t     o_row_idx,
  output win_sum_t o_win_sum,
  output pix_t     o_center
);

  localparam int DLY     = `BF_WIN;
  // half a window of columns plus the tree and total stages.
  localparam int CTR_DLY = (`BF_WIN - 1) / 2 + 5;

  pix_t        c1, c2, c3, c4, c5, c6, c7, c8, c9;
  logic [8:0]  s12, s34, s56, s78;
  logic [9:0]  s1234, s5678;
  logic [10:0] s18;
  pix_t        p9_d [3];
  col_sum_t    col_sum;
  col_sum_t    cs_dly [DLY];
  win_sum_t    cs_new;
  win_sum_t    cs_old;
  win_sum_t    total;
  pix_t        ctr_dly [CTR_DLY];
  logic        col_last;

  // --------------------------------------------------
  // column adder tree
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      c1      <= '0;
      c2      <= '0;
      c3      <= '0;
      c4      <= '0;
      c5      <= '0;
      c6      <= '0;
      c7      <= '0;
      c8      <= '0;
      c9      <= '0;
      s12     <= '0;
      s34     <= '0;
      s56     <= '0;
      s78     <= '0;
      s1234   <= '0;
      s5678   <= '0;
      s18     <= '0;
      col_sum <= '0;
      for (int k = 0; k < 3; k++) begin
        p9_d[k] <= '0;
      end
    end else begin
      c1      <= i_p1;
      c2      <= i_p2;
      c3      <= i_p3;
      c4      <= i_p4;
      c5      <= i_p5;
      c6      <= i_p6;
      c7      <= i_p7;
      c8      <= i_p8;
      c9      <= i_p9;
      s12     <= {1'b0, c1} + {1'b0, c2};
      s34     <= {1'b0, c3} + {1'b0, c4};
      s56     <= {1'b0, c5} + {1'b0, c6};
      s78     <= {1'b0, c7} + {1'b0, c8};
      s1234   <= {1'b0, s12} + {1'b0, s34};
      s5678   <= {1'b0, s56} + {1'b0, s78};
      s18     <= {1'b0, s1234} + {1'b0, s5678};
      // bottom pixel joins at the last level.
      p9_d[0] <= c9;
      p9_d[1] <= p9_d[0];
      p9_d[2] <= p9_d[1];
      col_sum <= {1'b0, s18} + {4'b0, p9_d[2]};
    end
  end

  // --------------------------------------------------
  // running window total
  // --------------------------------------------------
  assign cs_new = win_sum_t'(col_sum);
  assign cs_old = i_sub_en ? win_sum_t'(cs_dly[DLY-1]) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      total <= '0;
      for (int k = 0; k < DLY; k++) begin
        cs_dly[k] <= '0;
      end
      for (int k = 0; k < CTR_DLY; k++) begin
        ctr_dly[k] <= '0;
      end
    end else begin
      if (i_ld_en) begin
        total <= cs_new;
      end else begin
        total <= total + cs_new - cs_old;
      end
      cs_dly[0]  <= col_sum;
      ctr_dly[0] <= c5;
      for (int k = 1; k < DLY; k++) begin
        cs_dly[k] <= cs_dly[k-1];
      end
      for (int k = 1; k < CTR_DLY; k++) begin
        ctr_dly[k] <= ctr_dly[k-1];
      end
    end
  end

  assign o_win_sum = total;
  assign o_center  = ctr_dly[CTR_DLY-1];

  // position of the pixel being accepted now.
  assign col_last = (o_col_idx == cnt_t'(`BF_COLS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_col_idx <= '0;
      o_row_idx <= '0;
    end else if (i_clr) begin
      o_col_idx <= '0;
      o_row_idx <= '0;
    end else if (i_valid) begin
      if (col_last) begin
        o_col_idx <= '0;
        o_row_idx <= o_row_idx + 1'b1;
      end else begin
        o_col_idx <= o_col_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/filter_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "bf_consts.svh"

module filter_ctrl
  import bf_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic i_frame_start,
  input  logic i_pix_valid,
  input  cnt_t i_col_idx,
  input  cnt_t i_row_idx,
  output logic o_clr,
  output logic o_ld_en,
  output logic o_sub_en,
  output logic o_out_en,
  output logic o_busy
);

  localparam int TOT_DLY = `BF_LAT - 1;
  localparam int OUT_DLY = `BF_LAT;
  localparam int DRN_W   = $clog2(`BF_LAT + 1);
  // first column and row that close a full window.
  localparam int EDGE    = `BF_WIN - 1;

  ctrl_state_t        state, state_nxt;
  logic [DRN_W-1:0]   drain_cnt;
  logic               last_pix;
  logic               ld_dec, sub_dec, out_dec;
  logic [TOT_DLY-1:0] ld_sr, sub_sr;
  logic [OUT_DLY-1:0] out_sr;

  assign last_pix = i_pix_valid && (i_col_idx == cnt_t'(`BF_COLS - 1))
                    && (i_row_idx == cnt_t'(`BF_ROWS - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (i_frame_start) state_nxt = ST_FILL;
      ST_FILL: if (i_row_idx >= cnt_t'(EDGE)) state_nxt = ST_RUN;
      ST_RUN:  if (last_pix) state_nxt = ST_DONE;
      ST_DONE: begin
        if (i_frame_start) begin
          state_nxt = ST_FILL;
        end else if (drain_cnt == DRN_W'(`BF_LAT)) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      drain_cnt <= '0;
    end else begin
      state     <= state_nxt;
      drain_cnt <= (state == ST_DONE) ? drain_cnt + 1'b1 : '0;
    end
  end

  // --------------------------------------------------
  // strobes, decoded at accept and aligned to the data
  // --------------------------------------------------
  assign ld_dec  = i_pix_valid && (i_col_idx == '0);
  assign sub_dec = i_pix_valid && (i_col_idx >= cnt_t'(`BF_WIN));
  assign out_dec = (state == ST_RUN) && i_pix_valid
                   && (i_col_idx >= cnt_t'(EDGE)) && (i_row_idx >= cnt_t'(EDGE));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_sr  <= '0;
      sub_sr <= '0;
      out_sr <= '0;
    end else begin
      ld_sr  <= {ld_sr[TOT_DLY-2:0], ld_dec};
      sub_sr <= {sub_sr[TOT_DLY-2:0], sub_dec};
      out_sr <= {out_sr[OUT_DLY-2:0], out_dec};
    end
  end

  assign o_clr    = i_frame_start;
  assign o_ld_en  = ld_sr[TOT_DLY-1];
  assign o_sub_en = sub_sr[TOT_DLY-1];
  assign o_out_en = out_sr[OUT_DLY-1];
  assign o_busy   = (state != ST_IDLE);

endmodule

`default_nettype wire

// File: design/threshold_out.sv
`timescale 1ns/100ps
`default_nettype none

module threshold_out
  import bf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_out_en,
  input  win_sum_t i_win_sum,
  input  pix_t     i_center,
  output logic     o_valid,
  output win_sum_t o_win_sum,
  output pix_t     o_center,
  output logic     o_bin
);

  win_sum_t ctr_ext;
  win_sum_t ctr_x81;

  // 81 = 64 + 16 + 1, at most 20655.
  assign ctr_ext = win_sum_t'(i_center);
  assign ctr_x81 = (ctr_ext << 6) + (ctr_ext << 4) + ctr_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid   <= 1'b0;
      o_win_sum <= '0;
      o_center  <= '0;
      o_bin     <= 1'b0;
    end else begin
      o_valid <= i_out_en;
      if (i_out_en) begin
        o_win_sum <= i_win_sum;
        o_center  <= i_center;
        o_bin     <= (ctr_x81 > i_win_sum);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/box_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

module box_filter_top
  import bf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_frame_start,
  input  logic     i_pix_valid,
  input  pix_t     i_pix,
  output logic     o_valid,
  output logic     o_bin,
  output logic     o_busy,
  output win_sum_t o_win_sum,
  output pix_t     o_center
);

  pix_t     col_p1, col_p2, col_p3, col_p4, col_p5;
  pix_t     col_p6, col_p7, col_p8, col_p9;
  cnt_t     col_idx, row_idx;
  win_sum_t win_sum;
  pix_t     center;
  logic     clr, ld_en, sub_en, out_en;

  line_buffer line_buffer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix_valid (i_pix_valid),
    .i_pix       (i_pix),
    .o_p1        (col_p1),
    .o_p2        (col_p2),
    .o_p3        (col_p3),
    .o_p4        (col_p4),
    .o_p5        (col_p5),
    .o_p6        (col_p6),
    .o_p7        (col_p7),
    .o_p8        (col_p8),
    .o_p9        (col_p9)
  );

  window_sum window_sum_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_p1      (col_p1),
    .i_p2      (col_p2),
    .i_p3      (col_p3),
    .i_p4      (col_p4),
    .i_p5      (col_p5),
    .i_p6      (col_p6),
    .i_p7      (col_p7),
    .i_p8      (col_p8),
    .i_p9      (col_p9),
    .i_valid   (i_pix_valid),
    .i_clr     (clr),
    .i_ld_en   (ld_en),
    .i_sub_en  (sub_en),
    .o_col_idx (col_idx),
    .o_row_idx (row_idx),
    .o_win_sum (win_sum),
    .o_center  (center)
  );

  filter_ctrl filter_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_frame_start (i_frame_start),
    .i_pix_valid   (i_pix_valid),
    .i_col_idx     (col_idx),
    .i_row_idx     (row_idx),
    .o_clr         (clr),
    .o_ld_en       (ld_en),
    .o_sub_en      (sub_en),
    .o_out_en      (out_en),
    .o_busy        (o_busy)
  );

  threshold_out threshold_out_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_out_en  (out_en),
    .i_win_sum (win_sum),
    .i_center  (center),
    .o_valid   (o_valid),
    .o_win_sum (o_win_sum),
    .o_center  (o_center),
    .o_bin     (o_bin)
  );

endmodule

`default_nettype wire

// File: test/box_filter_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "bf_consts.svh"

module box_filter_tb
  import bf_pkg::*;
();

  localparam int N_TESTS = 4;
  localparam int N_PIX   = `BF_COLS * `BF_ROWS;
  localparam int N_WIN   = (`BF_COLS - `BF_WIN + 1) * (`BF_ROWS - `BF_WIN + 1);
  localparam int HALF    = (`BF_WIN - 1) / 2;
  localparam int TIMEOUT = N_TESTS * (N_PIX + `BF_LAT + 20);

  typedef enum int {
    FILL_CONST,
    FILL_RAMP,
    FILL_RAND
  } fill_t;

  logic     clk;
  logic     rst_n;
  logic     i_frame_start;
  logic     i_pix_valid;
  pix_t     i_pix;
  logic     o_valid;
  logic     o_bin;
  logic     o_busy;
  win_sum_t o_win_sum;
  pix_t     o_center;

  // --------------------------------------------------
  // frame table
  // --------------------------------------------------
  // tb2b starts the frame the cycle after the previous one's last pixel.
  string tname  [N_TESTS] = '{"const_200", "ramp", "random", "random_b2b"};
  fill_t tmode  [N_TESTS] = '{FILL_CONST, FILL_RAMP, FILL_RAND, FILL_RAND};
  int    tconst [N_TESTS] = '{200, 0, 0, 0};
  bit    tb2b   [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};
  int    tnout  [N_TESTS] = '{N_WIN, N_WIN, N_WIN, N_WIN};

  int          frame [`BF_ROWS][`BF_COLS];
  win_sum_t    q_sum [$];
  pix_t        q_ctr [$];
  logic        q_bin [$];
  int          q_tag [$];
  int          q_cyc [$];
  int          test_err [N_TESTS];
  int          out_cnt  [N_TESTS];
  int          cyc        = 0;
  int          err_cnt    = 0;
  int          chk_cnt    = 0;
  int          chk_tag    = -1;
  string       chk_name   = "reset";
  bit          frame_seen = 1'b0;
  logic [15:0] lfsr;

  box_filter_top box_filter_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_frame_start (i_frame_start),
    .i_pix_valid   (i_pix_valid),
    .i_pix         (i_pix),
    .o_valid       (o_valid),
    .o_bin         (o_bin),
    .o_busy        (o_busy),
    .o_win_sum     (o_win_sum),
    .o_center      (o_center)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("ERROR: timeout, the run did not finish within %0d cycles", TIMEOUT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // stimulus and model
  // --------------------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_rand_pix(output pix_t p);
    for (int b = 0; b < 8; b++) begin
      lfsr = lfsr_step(lfsr);
      p    = {p[6:0], lfsr[0]};
    end
  endtask

  task automatic fill_frame(input int t);
    pix_t p;
    for (int r = 0; r < `BF_ROWS; r++) begin
      for (int c = 0; c < `BF_COLS; c++) begin
        case (tmode[t])
          FILL_CONST: frame[r][c] = tconst[t];
          FILL_RAMP:  frame[r][c] = c + 16 * r;
          default: begin
            next_rand_pix(p);
            frame[r][c] = int'(p);
          end
        endcase
      end
    end
  endtask

  // one expectation per bottom-right pixel, in raster order.
  task automatic queue_windows(input int t);
    int sum;
    int ctr;
    for (int r = `BF_WIN - 1; r < `BF_ROWS; r++) begin
      for (int c = `BF_WIN - 1; c < `BF_COLS; c++) begin
        sum = 0;
        for (int dr = 0; dr < `BF_WIN; dr++) begin
          for (int dc = 0; dc < `BF_WIN; dc++) begin
            sum += frame[r-dr][c-dc];
          end
        end
        ctr = frame[r-HALF][c-HALF];
        q_sum.push_back(win_sum_t'(sum));
        q_ctr.push_back(pix_t'(ctr));
        q_bin.push_back(ctr * 81 > sum);
        q_tag.push_back(t);
      end
    end
  endtask

  task automatic drive_frame();
    frame_seen    = 1'b1;
    i_frame_start = 1'b1;
    i_pix_valid   = 1'b0;
    @(posedge clk);
    #1;
    i_frame_start = 1'b0;
    for (int r = 0; r < `BF_ROWS; r++) begin
      for (int c = 0; c < `BF_COLS; c++) begin
        i_pix_valid = 1'b1;
        i_pix       = pix_t'(frame[r][c]);
        // accepted on the next edge, output lands BF_LAT edges later.
        if (r >= `BF_WIN - 1 && c >= `BF_WIN - 1) begin
          q_cyc.push_back(cyc + 1 + `BF_LAT);
        end
        @(posedge clk);
        #1;
      end
    end
    i_pix_valid = 1'b0;
    i_pix       = '0;
  endtask

  task automatic wait_idle();
    while (o_busy) begin
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk);
    #1;
  endtask

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  task automatic note_error();
    err_cnt++;
    if (chk_tag >= 0) begin
      test_err[chk_tag]++;
    end
  endtask

  task automatic check_sum(input string what, input win_sum_t exp, input win_sum_t act);
    chk_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", chk_name, what, exp, act);
      note_error();
    end
  endtask

  task automatic check_pix(input string what, input pix_t exp, input pix_t act);
    chk_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", chk_name, what, exp, act);
      note_error();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %b, actual %b", chk_name, what, exp, act);
      note_error();
    end
  endtask

  task automatic check_cycle(input string what, input int exp, input int act);
    chk_cnt++;
    if (act != exp) begin
      $display("MISMATCH %s %s: expected cycle %0d, actual cycle %0d",
               chk_name, what, exp, act);
      note_error();
    end
  endtask

  task automatic report_test(input int t);
    if (out_cnt[t] != tnout[t]) begin
      $display("ERROR: test %s produced %0d output strobes instead of %0d",
               tname[t], out_cnt[t], tnout[t]);
      err_cnt++;
      test_err[t]++;
    end
    $display("test %s: %s, %0d outputs, %0d errors", tname[t],
             (test_err[t] == 0) ? "pass" : "fail", out_cnt[t], test_err[t]);
  endtask

  // outputs are sampled mid-cycle.
  always @(negedge clk) begin
    if (rst_n && o_valid) begin
      if (q_sum.size() == 0) begin
        chk_tag = -1;
        if (!frame_seen) begin
          $display("ERROR: output strobe before any frame");
        end else begin
          $display("ERROR: extra output strobe with no window pending");
        end
        err_cnt++;
      end else begin
        chk_tag  = q_tag.pop_front();
        chk_name = tname[chk_tag];
        out_cnt[chk_tag]++;
        check_sum("window sum", q_sum.pop_front(), o_win_sum);
        check_pix("centre", q_ctr.pop_front(), o_center);
        check_bit("decision", q_bin.pop_front(), o_bin);
        check_cycle("latency", q_cyc.pop_front(), cyc);
        check_bit("busy", 1'b1, o_busy);
      end
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int first;
    int reset_err;
    rst_n         = 1'b0;
    i_frame_start = 1'b0;
    i_pix_valid   = 1'b0;
    i_pix         = '0;
    lfsr          = 16'd19;
    for (int t = 0; t < N_TESTS; t++) begin
      test_err[t] = 0;
      out_cnt[t]  = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    chk_tag  = -1;
    chk_name = "reset";
    repeat (4) begin
      @(posedge clk);
      #1;
      check_bit("o_valid", 1'b0, o_valid);
      check_bit("o_busy", 1'b0, o_busy);
    end
    reset_err = err_cnt;
    $display("test reset: %s, %0d errors", (reset_err == 0) ? "pass" : "fail", reset_err);

    first = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      fill_frame(t);
      queue_windows(t);
      drive_frame();
      if (t == N_TESTS - 1 || !tb2b[t+1]) begin
        wait_idle();
        for (int k = first; k <= t; k++) begin
          report_test(k);
        end
        first = t + 1;
      end
    end

    if (q_sum.size() != 0) begin
      $display("ERROR: %0d expected outputs never appeared", q_sum.size());
      err_cnt++;
    end
    $display("done: %0d tests, %0d checks, %0d errors", N_TESTS + 1, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: box_filter.f
+incdir+design
design/bf_pkg.sv
design/line_buffer.sv
design/window_sum.sv
design/filter_ctrl.sv
design/threshold_out.sv
design/box_filter_top.sv
test/box_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the box filter testbench with Verilator.
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/100ps --top-module box_filter_tb \
  -f box_filter.f -o box_filter_sim > build.log 2>&1 \
  && ./obj_dir/box_filter_sim > sim.log 2>&1 \
  || echo "build or simulation step returned an error, see build.log"
grep -qs "TESTBENCH PASSED" sim.log && echo "result: pass" && exit 0 \
  || { echo "result: fail, see sim.log"; exit 1; }
